/* common/bridgeCfgPkg.sv */
`default_nettype none

package bridgeCfgPkg;

    // channel tag is sized for the largest build
    parameter int MAX_CHAN = 4;
    parameter int CHAN_W = (MAX_CHAN > 1) ? $clog2(MAX_CHAN) : 1;

    // defaults picked up by the top level
    parameter int DEFAULT_DEPTH = 8; // entries per FIFO
    parameter int DEFAULT_NUM_CHAN = 4; // receive channels, at most MAX_CHAN

endpackage

`default_nettype wire

/* common/bridgeTypesPkg.sv */
`default_nettype none

package bridgeTypesPkg;

    typedef logic [bridgeCfgPkg::CHAN_W-1:0] chanId;

    // one received byte with the channel it arrived on
    typedef struct packed {
        chanId chan;
        logic [7:0] data;
    } rxByte;

    // one byte queued for the host
    typedef struct packed {
        logic [7:0] data;
        logic flush; // last byte of a message, like send-immediate
    } txEntry;

endpackage

`default_nettype wire

/* verilog/ringFifo.sv */
`timescale 1ns/1ps
`default_nettype none

module ringFifo #(
    parameter int DEPTH = bridgeCfgPkg::DEFAULT_DEPTH,
    parameter type payloadT = logic [7:0]
) (
    input wire _RD,
    input wire rst,
    input wire push,
    input wire payloadT pushData,
    input wire pop,
    output payloadT headData,
    output logic empty,
    output logic full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payloadT mem [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;
    logic doPush;
    logic doPop;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1; // wrap at DEPTH
    endfunction

    assign full = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);
    assign doPush = push && !full; // push on full is dropped
    assign doPop = pop && !empty;
    assign headData = mem[rdPtr]; // head visible without a pop

    always_ff @(posedge _RD) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge _RD) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            // simultaneous push and pop leaves count alone
            case ({doPush, doPop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rxPath/channelSteer.sv */
`timescale 1ns/1ps
`default_nettype none

module channelSteer #(
    parameter int NUM_CHAN = bridgeCfgPkg::DEFAULT_NUM_CHAN
) (
    input wire _RD,
    input wire rst,
    input wire hostPush,
    input wire bridgeTypesPkg::rxByte hostByte,
    input wire [NUM_CHAN-1:0] fifoFull,
    output logic [NUM_CHAN-1:0] fifoPush,
    output logic [NUM_CHAN-1:0] overflow
);

    logic [NUM_CHAN-1:0] hit;
    logic [NUM_CHAN-1:0] refused;

    // one-hot decode of the tag, tags past NUM_CHAN go nowhere
    always_comb begin
        hit = '0;
        if (hostPush && (int'(hostByte.chan) < NUM_CHAN)) begin
            hit[hostByte.chan] = 1'b1;
        end
    end

    assign fifoPush = hit & ~fifoFull;
    assign refused = hit & fifoFull; // byte silently lost

    // sticky until reset
    always_ff @(posedge _RD) begin
        if (rst) begin
            overflow <= '0;
        end else begin
            overflow <= overflow | refused;
        end
    end

endmodule

`default_nettype wire

/* rxPath/rxArbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module rxArbiter #(
    parameter int NUM_CHAN = bridgeCfgPkg::DEFAULT_NUM_CHAN
) (
    input wire _RD,
    input wire rst,
    input wire bridgeTypesPkg::rxByte [NUM_CHAN-1:0] fifoHead,
    input wire [NUM_CHAN-1:0] fifoEmpty,
    output logic [NUM_CHAN-1:0] fifoPop,
    input wire readStrobe,
    output logic rxReady,
    output bridgeTypesPkg::rxByte rxData
);

    bridgeTypesPkg::chanId rrPtr; // first channel to look at
    bridgeTypesPkg::chanId pick;
    int cand;
    logic found;
    logic doLoad;
    logic consume;
    logic regFull; // read register holds a byte
    logic recover; // inactive period after a read

    // first non-empty channel at or after rrPtr
    always_comb begin
        found = 1'b0;
        pick = '0;
        cand = 0;
        for (int i = 0; i < NUM_CHAN; i++) begin
            cand = (int'(rrPtr) + i) % NUM_CHAN;
            if (!found && !fifoEmpty[cand]) begin
                found = 1'b1;
                pick = bridgeTypesPkg::chanId'(cand);
            end
        end
    end

    assign doLoad = !regFull && !recover && found;
    assign consume = readStrobe && rxReady; // strobe while not ready is ignored

    always_comb begin
        fifoPop = '0;
        if (doLoad) begin
            fifoPop[pick] = 1'b1;
        end
    end

    always_ff @(posedge _RD) begin
        if (doLoad) begin
            rxData <= fifoHead[pick];
        end
    end

    always_ff @(posedge _RD) begin
        if (rst) begin
            regFull <= 1'b0;
            recover <= 1'b0;
            rxReady <= 1'b0;
            rrPtr <= '0;
        end else begin
            recover <= consume;
            // ready follows the register one cycle late
            rxReady <= regFull && !consume;
            if (consume) begin
                regFull <= 1'b0;
            end else if (doLoad) begin
                regFull <= 1'b1;
            end
            if (doLoad) begin
                rrPtr <= bridgeTypesPkg::chanId'((int'(pick) + 1) % NUM_CHAN);
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/txPath.sv */
`timescale 1ns/1ps
`default_nettype none

module txPath #(
    parameter int DEPTH = bridgeCfgPkg::DEFAULT_DEPTH
) (
    input wire _RD,
    input wire rst,
    input wire writeStrobe,
    input wire bridgeTypesPkg::txEntry txData,
    output logic txReady,
    input wire hostTxAccept,
    output logic hostTxValid,
    output bridgeTypesPkg::txEntry hostTxData
);

    logic full;
    logic empty;
    logic recover; // one dead cycle after each write
    logic doPush;
    logic doPop;

    assign txReady = !recover && !full;
    assign doPush = writeStrobe && txReady; // writes while not ready are lost
    assign hostTxValid = !empty;
    assign doPop = hostTxAccept && !empty;

    always_ff @(posedge _RD) begin
        if (rst) begin
            recover <= 1'b0;
        end else begin
            recover <= doPush;
        end
    end

    ringFifo #(
        .DEPTH(DEPTH),
        .payloadT(bridgeTypesPkg::txEntry)
    ) txFifo_inst (
        ._RD(_RD),
        .rst(rst),
        .push(doPush),
        .pushData(txData),
        .pop(doPop),
        .headData(hostTxData),
        .empty(empty),
        .full(full)
    );

endmodule

`default_nettype wire

/* verilog/usbFifoBridge.sv */
`timescale 1ns/1ps
`default_nettype none

module usbFifoBridge #(
    parameter int NUM_CHAN = bridgeCfgPkg::DEFAULT_NUM_CHAN,
    parameter int DEPTH = bridgeCfgPkg::DEFAULT_DEPTH
) (
    input wire _RD,
    input wire rst,
    // host receive side
    input wire hostPush,
    input wire bridgeTypesPkg::rxByte hostByte,
    output wire [NUM_CHAN-1:0] chanFull,
    output wire [NUM_CHAN-1:0] overflow,
    // CPU read side
    input wire readStrobe,
    output wire rxReady,
    output bridgeTypesPkg::rxByte rxData,
    // CPU write side
    input wire writeStrobe,
    input wire bridgeTypesPkg::txEntry txData,
    output wire txReady,
    // host transmit side
    input wire hostTxAccept,
    output wire hostTxValid,
    output bridgeTypesPkg::txEntry hostTxData
);

    wire [NUM_CHAN-1:0] chanPush;
    wire [NUM_CHAN-1:0] chanPop;
    wire [NUM_CHAN-1:0] chanEmpty;
    bridgeTypesPkg::rxByte [NUM_CHAN-1:0] chanHead;

    channelSteer #(
        .NUM_CHAN(NUM_CHAN)
    ) channelSteer_inst (
        ._RD(_RD),
        .rst(rst),
        .hostPush(hostPush),
        .hostByte(hostByte),
        .fifoFull(chanFull),
        .fifoPush(chanPush),
        .overflow(overflow)
    );

    // one receive FIFO per channel
    for (genvar g = 0; g < NUM_CHAN; g++) begin : gChan
        ringFifo #(
            .DEPTH(DEPTH),
            .payloadT(bridgeTypesPkg::rxByte)
        ) rxFifo_inst (
            ._RD(_RD),
            .rst(rst),
            .push(chanPush[g]),
            .pushData(hostByte),
            .pop(chanPop[g]),
            .headData(chanHead[g]),
            .empty(chanEmpty[g]),
            .full(chanFull[g])
        );
    end

    rxArbiter #(
        .NUM_CHAN(NUM_CHAN)
    ) rxArbiter_inst (
        ._RD(_RD),
        .rst(rst),
        .fifoHead(chanHead),
        .fifoEmpty(chanEmpty),
        .fifoPop(chanPop),
        .readStrobe(readStrobe),
        .rxReady(rxReady),
        .rxData(rxData)
    );

    txPath #(
        .DEPTH(DEPTH)
    ) txPath_inst (
        ._RD(_RD),
        .rst(rst),
        .writeStrobe(writeStrobe),
        .txData(txData),
        .txReady(txReady),
        .hostTxAccept(hostTxAccept),
        .hostTxValid(hostTxValid),
        .hostTxData(hostTxData)
    );

endmodule

`default_nettype wire

/* tests/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int PERIOD = 20, // ns
    parameter int RESET_CYCLES = 2,
    parameter int DRIVE_DELAY = 2 // ns after the rising edge
) (
    output logic _RD,
    output logic rst
);

    initial begin
        _RD = 1'b0;
        forever begin
            #(PERIOD / 2) _RD = ~_RD;
        end
    end

    // reset drops just after an edge, like the other inputs
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge _RD);
        #DRIVE_DELAY;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* tests/usbFifoBridgeTb.sv */
`timescale 1ns/1ps
`default_nettype none

module usbFifoBridgeTb;

    localparam int NUM_CHAN = 4;
    localparam int DEPTH = 8;
    localparam int DRIVE_DELAY = 2; // ns after the rising edge
    localparam int WAIT_LIMIT = 40; // cycles per wait
    localparam int SEL_RX = 0;
    localparam int SEL_TX = 1;
    localparam int SEL_HOST = 2;

    wire _RD;
    wire rst;
    logic hostPush;
    bridgeTypesPkg::rxByte hostByte;
    wire [NUM_CHAN-1:0] chanFull;
    wire [NUM_CHAN-1:0] overflow;
    logic readStrobe;
    wire rxReady;
    bridgeTypesPkg::rxByte rxData;
    logic writeStrobe;
    bridgeTypesPkg::txEntry txData;
    wire txReady;
    logic hostTxAccept;
    wire hostTxValid;
    bridgeTypesPkg::txEntry hostTxData;
    integer seed = 32'h89d5;

    clockGen #(
        .PERIOD(20),
        .RESET_CYCLES(2),
        .DRIVE_DELAY(DRIVE_DELAY)
    ) clockGen_inst (
        ._RD(_RD),
        .rst(rst)
    );

    usbFifoBridge #(
        .NUM_CHAN(NUM_CHAN),
        .DEPTH(DEPTH)
    ) usbFifoBridge_inst (
        ._RD(_RD),
        .rst(rst),
        .hostPush(hostPush),
        .hostByte(hostByte),
        .chanFull(chanFull),
        .overflow(overflow),
        .readStrobe(readStrobe),
        .rxReady(rxReady),
        .rxData(rxData),
        .writeStrobe(writeStrobe),
        .txData(txData),
        .txReady(txReady),
        .hostTxAccept(hostTxAccept),
        .hostTxValid(hostTxValid),
        .hostTxData(hostTxData)
    );

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    // outputs are sampled and inputs driven at this point
    task automatic nextCycle();
        @(posedge _RD);
        #DRIVE_DELAY;
    endtask

    task automatic idle(input int n);
        repeat (n) nextCycle();
    endtask

    task automatic checkRxByte(input string what, input bridgeTypesPkg::rxByte got,
                               input bridgeTypesPkg::rxByte exp);
        if (got !== exp) begin
            failRun($sformatf("Error at %0t ns: %s is chan %0d data %02h, expected chan %0d data %02h",
                $time, what, got.chan, got.data, exp.chan, exp.data));
        end
    endtask

    task automatic checkTxEntry(input string what, input bridgeTypesPkg::txEntry got,
                                input bridgeTypesPkg::txEntry exp);
        if (got !== exp) begin
            failRun($sformatf("Error at %0t ns: %s is data %02h flush %b, expected %02h flush %b",
                $time, what, got.data, got.flush, exp.data, exp.flush));
        end
    endtask

    task automatic checkFlags(input string what, input logic [NUM_CHAN-1:0] got,
                              input logic [NUM_CHAN-1:0] exp);
        if (got !== exp) begin
            failRun($sformatf("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic checkLevel(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            failRun($sformatf("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    function automatic logic levelOf(input int sel);
        case (sel)
            SEL_RX: return rxReady;
            SEL_TX: return txReady;
            default: return hostTxValid;
        endcase
    endfunction

    task automatic waitHigh(input int sel, input string what);
        int cycles;
        cycles = 0;
        while (levelOf(sel) !== 1'b1) begin
            if (cycles >= WAIT_LIMIT) begin
                failRun($sformatf("Timeout: %s did not go high within %0d cycles",
                    what, WAIT_LIMIT));
            end
            nextCycle();
            cycles++;
        end
    endtask

    // rst is looked at on the edge, where it is stable
    task automatic waitReset();
        int cycles;
        cycles = 0;
        forever begin
            @(posedge _RD);
            if (rst === 1'b0) begin
                break;
            end
            if (cycles >= WAIT_LIMIT) begin
                failRun("Timeout: reset was never released");
            end
            cycles++;
        end
        #DRIVE_DELAY;
    endtask

    function automatic logic [7:0] randByte();
        return 8'($random(seed));
    endfunction

    function automatic bridgeTypesPkg::rxByte makeRx(input int ch, input logic [7:0] data);
        bridgeTypesPkg::rxByte b;
        b.chan = bridgeTypesPkg::chanId'(ch);
        b.data = data;
        return b;
    endfunction

    function automatic logic [NUM_CHAN-1:0] chanBit(input int ch);
        logic [NUM_CHAN-1:0] v;
        v = '0;
        v[ch] = 1'b1;
        return v;
    endfunction

    task automatic pushEntry(input bridgeTypesPkg::rxByte b);
        hostPush = 1'b1;
        hostByte = b;
        nextCycle();
        hostPush = 1'b0;
    endtask

    task automatic readAndCheck(input bridgeTypesPkg::rxByte exp);
        waitHigh(SEL_RX, "rxReady");
        checkRxByte("rxData", rxData, exp);
        readStrobe = 1'b1;
        nextCycle();
        readStrobe = 1'b0;
        checkLevel("rxReady right after read", rxReady, 1'b0);
        nextCycle();
        checkLevel("rxReady in read recovery", rxReady, 1'b0);
    endtask

    task automatic resetValues();
        checkLevel("rxReady after reset", rxReady, 1'b0);
        checkLevel("hostTxValid after reset", hostTxValid, 1'b0);
        checkLevel("txReady after reset", txReady, 1'b1);
        checkFlags("chanFull after reset", chanFull, '0);
        checkFlags("overflow after reset", overflow, '0);
    endtask

    task automatic singleChannelOrder();
        bridgeTypesPkg::rxByte expQ[$];
        bridgeTypesPkg::rxByte b;
        b = makeRx(2, randByte());
        expQ.push_back(b);
        pushEntry(b);
        checkLevel("rxReady after push edge", rxReady, 1'b0);
        nextCycle();
        checkLevel("rxReady one cycle after push", rxReady, 1'b0);
        nextCycle();
        checkLevel("rxReady two cycles after push", rxReady, 1'b1);
        for (int i = 0; i < 5; i++) begin
            b = makeRx(2, randByte());
            expQ.push_back(b);
            pushEntry(b);
        end
        while (expQ.size() > 0) begin
            readAndCheck(expQ.pop_front());
        end
    endtask

    task automatic roundRobinOrder();
        bridgeTypesPkg::rxByte sent [NUM_CHAN][3];
        for (int ch = 0; ch < NUM_CHAN; ch++) begin
            for (int i = 0; i < 3; i++) begin
                sent[ch][i] = makeRx(ch, randByte());
                pushEntry(sent[ch][i]);
            end
        end
        // service rotates over the channels, oldest byte first in each
        for (int i = 0; i < 3; i++) begin
            for (int ch = 0; ch < NUM_CHAN; ch++) begin
                readAndCheck(sent[ch][i]);
            end
        end
    endtask

    task automatic rxOverflow();
        bridgeTypesPkg::rxByte sent [DEPTH+2];
        checkFlags("overflow before pushes", overflow, '0);
        for (int i = 0; i < DEPTH + 2; i++) begin
            sent[i] = makeRx(1, randByte());
            pushEntry(sent[i]);
        end
        checkFlags("chanFull after pushes", chanFull, chanBit(1));
        checkFlags("overflow after pushes", overflow, chanBit(1));
        // FIFO plus the read register
        for (int i = 0; i < DEPTH + 1; i++) begin
            readAndCheck(sent[i]);
        end
        for (int i = 0; i < 6; i++) begin
            nextCycle();
            checkLevel("rxReady after drain", rxReady, 1'b0);
        end
        checkFlags("chanFull after drain", chanFull, '0);
        checkFlags("overflow stays set", overflow, chanBit(1));
    endtask

    task automatic txDrain();
        bridgeTypesPkg::txEntry sent [DEPTH];
        bridgeTypesPkg::txEntry junk;
        logic [7:0] r;
        logic expReady;
        for (int i = 0; i < DEPTH; i++) begin
            r = randByte();
            sent[i].data = randByte();
            sent[i].flush = r[0];
            waitHigh(SEL_TX, "txReady");
            writeStrobe = 1'b1;
            txData = sent[i];
            nextCycle();
            writeStrobe = 1'b0;
            checkLevel("txReady right after write", txReady, 1'b0);
            if (i == 0) begin
                checkLevel("hostTxValid after first write", hostTxValid, 1'b1);
            end
            nextCycle();
            expReady = (i < DEPTH - 1); // low once the FIFO is full
            checkLevel("txReady after write recovery", txReady, expReady);
        end
        junk.data = ~sent[0].data;
        junk.flush = 1'b1;
        writeStrobe = 1'b1; // full, must be ignored
        txData = junk;
        nextCycle();
        writeStrobe = 1'b0;
        for (int i = 0; i < 3; i++) begin
            checkLevel("txReady while full", txReady, 1'b0);
            nextCycle();
        end
        for (int i = 0; i < DEPTH; i++) begin
            waitHigh(SEL_HOST, "hostTxValid");
            checkTxEntry("hostTxData", hostTxData, sent[i]);
            hostTxAccept = 1'b1;
            nextCycle();
            hostTxAccept = 1'b0;
        end
        checkLevel("hostTxValid after drain", hostTxValid, 1'b0);
        checkLevel("txReady after drain", txReady, 1'b1);
    endtask

    initial begin
        hostPush = 1'b0;
        hostByte = '0;
        readStrobe = 1'b0;
        writeStrobe = 1'b0;
        txData = '0;
        hostTxAccept = 1'b0;
        waitReset();
        resetValues();
        singleChannelOrder();
        idle(3);
        roundRobinOrder();
        idle(3);
        rxOverflow();
        idle(3);
        txDrain();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* usbFifoBridge.f */
common/bridgeCfgPkg.sv
common/bridgeTypesPkg.sv
verilog/ringFifo.sv
rxPath/channelSteer.sv
rxPath/rxArbiter.sv
verilog/txPath.sv
verilog/usbFifoBridge.sv
tests/clockGen.sv
tests/usbFifoBridgeTb.sv

/* run.sh */
#!/usr/bin/env bash
# builds and runs the usbFifoBridge testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

TOP=usbFifoBridgeTb
BUILD_DIR=obj_dir

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator was not found in PATH"
    exit 1
fi

verilator --binary --timing --top-module "$TOP" --Mdir "$BUILD_DIR" -f usbFifoBridge.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit "$status"
fi

"./$BUILD_DIR/V$TOP"
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

echo "simulation ended with status 0"
exit 0
